/* hw/usb_defs_pkg.sv */
package usb_defs_pkg;

  // Data PIDs as carried on the encoder's tuser lane
  localparam logic [3:0] pid_data0 = 4'b0011;
  localparam logic [3:0] pid_data1 = 4'b1011;

  // Standard bRequest codes
  localparam logic [7:0] req_get_status        = 8'h00;
  localparam logic [7:0] req_set_address       = 8'h05;
  localparam logic [7:0] req_get_descriptor    = 8'h06;
  localparam logic [7:0] req_get_configuration = 8'h08;
  localparam logic [7:0] req_set_configuration = 8'h09;

  // Descriptor types in the high byte of wValue
  localparam logic [7:0] desc_device        = 8'h01;
  localparam logic [7:0] desc_configuration = 8'h02;
  localparam logic [7:0] desc_string        = 8'h03;

  localparam int max_packet = 64;

  // Fields listed MSB first, so bmRequestType lands in byte 0
  typedef struct packed {
    logic [15:0] w_length;
    logic [15:0] w_index;
    logic [15:0] w_value;
    logic [7:0]  b_request;
    logic [7:0]  bm_request_type;
  } setup_fields_t;

  typedef union packed {
    setup_fields_t   fields;
    logic [7:0][7:0] bytes;
  } setup_packet_u;

  localparam int device_len  = 18;
  localparam int config_len  = 18;
  localparam int string0_len = 4;
  localparam int string1_len = 16;
  localparam int string2_len = 20;
  localparam int string3_len = 14;

  localparam logic [0:device_len-1][7:0] device_desc = {
    8'h12, 8'h01, 8'h00, 8'h02, 8'h00, 8'h00, 8'h00, 8'(max_packet),
    8'hCE, 8'hF4, 8'h03, 8'h00, 8'h00, 8'h01, 8'h01, 8'h02, 8'h03, 8'h01
  };

  // Configuration header followed by a single interface without endpoints
  localparam logic [0:config_len-1][7:0] config_desc = {
    8'h09, 8'h02, 8'h12, 8'h00, 8'h01, 8'h01, 8'h00, 8'h80, 8'h32,
    8'h09, 8'h04, 8'h00, 8'h00, 8'h00, 8'hFF, 8'h00, 8'h00, 8'h00
  };

  // Supported language list, US English only
  localparam logic [0:string0_len-1][7:0] string0_desc = {8'h04, 8'h03, 8'h09, 8'h04};

  // "OPEN HW"
  localparam logic [0:string1_len-1][7:0] string1_desc = {
    8'h10, 8'h03, 8'h4F, 8'h00, 8'h50, 8'h00, 8'h45, 8'h00,
    8'h4E, 8'h00, 8'h20, 8'h00, 8'h48, 8'h00, 8'h57, 8'h00
  };

  // "CTRL UNIT"
  localparam logic [0:string2_len-1][7:0] string2_desc = {
    8'h14, 8'h03, 8'h43, 8'h00, 8'h54, 8'h00, 8'h52, 8'h00, 8'h4C, 8'h00,
    8'h20, 8'h00, 8'h55, 8'h00, 8'h4E, 8'h00, 8'h49, 8'h00, 8'h54, 8'h00
  };

  // "SN0001"
  localparam logic [0:string3_len-1][7:0] string3_desc = {
    8'h0E, 8'h03, 8'h53, 8'h00, 8'h4E, 8'h00, 8'h30, 8'h00,
    8'h30, 8'h00, 8'h30, 8'h00, 8'h31, 8'h00
  };

endpackage

/* hw/ctrl_pkg.sv */
package ctrl_pkg;

  typedef enum logic [1:0] {
    st_idle,
    st_setup,
    st_data,
    st_status
  } stage_e;

  // One-hot codes of the stage machine
  localparam logic [3:0] oh_idle   = 4'b0001;
  localparam logic [3:0] oh_setup  = 4'b0010;
  localparam logic [3:0] oh_data   = 4'b0100;
  localparam logic [3:0] oh_status = 4'b1000;

  typedef enum logic [2:0] {
    k_get_desc,
    k_get_conf,
    k_get_status,
    k_set_addr,
    k_set_conf,
    k_unsupported
  } kind_e;

  typedef struct packed {
    logic        dir_in;
    kind_e       kind;
    logic [7:0]  desc_type;
    logic [7:0]  desc_index;
    logic [7:0]  value;
    logic [15:0] length;
  } request_t;

  typedef struct packed {
    logic [6:0] address;
    logic [2:0] conf_num;
    logic       configured;
    logic       enumerated;
  } dev_state_t;

endpackage

/* hw/setup_collector.sv */
`timescale 1ns/1ps

module setup_collector (
  input  logic               clock,
  input  logic               reset,
  input  ctrl_pkg::stage_e   stage_i,
  input  logic               s_tvalid_i,
  input  logic               s_tlast_i,
  input  logic [7:0]         s_tdata_i,
  output logic               s_tready_o,
  output ctrl_pkg::request_t request_o,
  output logic               request_valid_o,
  output logic               malformed_o
);
  import ctrl_pkg::*;
  import usb_defs_pkg::*;

  setup_packet_u pkt;
  setup_fields_t fields;
  logic [2:0]    count;
  logic          full;
  logic          accept;
  logic          last_byte;
  logic          desc_known;

  assign s_tready_o = (stage_i == st_setup) && !full;
  assign accept     = s_tvalid_i && s_tready_o;
  assign last_byte  = (count == 3'd7);

  // Counter and status flags restart whenever the setup stage is left
  always_ff @(posedge clock) begin
    if (reset || stage_i != st_setup) begin
      count           <= '0;
      full            <= 1'b0;
      request_valid_o <= 1'b0;
      malformed_o     <= 1'b0;
    end else begin
      request_valid_o <= accept && s_tlast_i && last_byte;
      malformed_o     <= accept && (s_tlast_i != last_byte);
      if (accept) begin
        count <= count + 3'd1;
        if (s_tlast_i || last_byte) begin
          full <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      pkt.bytes[count] <= s_tdata_i;
    end
  end

  assign fields = pkt.fields;

  // Only descriptors with a stored copy count as known
  assign desc_known = (fields.w_value[15:8] == desc_device && fields.w_value[7:0] == 8'd0) ||
                      (fields.w_value[15:8] == desc_configuration &&
                       fields.w_value[7:0] == 8'd0) ||
                      (fields.w_value[15:8] == desc_string && fields.w_value[7:0] <= 8'd3);

  always_comb begin
    request_o.dir_in     = fields.bm_request_type[7];
    request_o.desc_type  = fields.w_value[15:8];
    request_o.desc_index = fields.w_value[7:0];
    request_o.value      = fields.w_value[7:0];
    request_o.length     = fields.w_length;
    request_o.kind       = k_unsupported;
    // Standard requests only, class and vendor types fall through to a stall
    if (fields.bm_request_type[6:5] == 2'b00) begin
      case (fields.b_request)
        req_get_status:
          if (request_o.dir_in) request_o.kind = k_get_status;
        req_set_address:
          if (!request_o.dir_in && fields.w_value[15:7] == '0) request_o.kind = k_set_addr;
        req_get_descriptor:
          if (request_o.dir_in && desc_known) request_o.kind = k_get_desc;
        req_get_configuration:
          if (request_o.dir_in) request_o.kind = k_get_conf;
        req_set_configuration:
          if (!request_o.dir_in && fields.w_value[15:3] == '0) request_o.kind = k_set_conf;
        default: request_o.kind = k_unsupported;
      endcase
    end
  end

endmodule

/* hw/control_stage_fsm.sv */
`timescale 1ns/1ps

module control_stage_fsm (
  input  logic               clock,
  input  logic               reset,
  input  logic               select_i,
  input  logic               start_i,
  input  logic               hsk_sent_i,
  input  logic               hsk_recv_i,
  input  logic               timeout_i,
  input  ctrl_pkg::request_t request_i,
  input  logic               request_valid_i,
  input  logic               malformed_i,
  output ctrl_pkg::stage_e   stage_o,
  output logic               commit_o,
  output logic               finish_o,
  output logic               stall_o
);
  import ctrl_pkg::*;

  logic [3:0] state;
  logic [3:0] state_next;
  logic       req_seen;
  logic       bad_request;
  logic       handshake;

  assign handshake   = hsk_sent_i || hsk_recv_i;
  assign bad_request = malformed_i || (request_valid_i && request_i.kind == k_unsupported);

  always_comb begin
    state_next = state;
    case (state)
      oh_idle:
        if (start_i) begin
          state_next = oh_setup;
        end
      oh_setup:
        if (bad_request || timeout_i) begin
          state_next = oh_idle;
        end else if (req_seen && hsk_sent_i) begin
          // Requests without an IN data stage go straight to status
          state_next = request_i.dir_in ? oh_data : oh_status;
        end
      oh_data:
        if (handshake) begin
          state_next = oh_status;
        end else if (timeout_i) begin
          state_next = oh_idle;
        end
      oh_status:
        if (handshake || timeout_i) begin
          state_next = oh_idle;
        end
      default: state_next = oh_idle;
    endcase

    if (!select_i) begin
      state_next = oh_idle;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state    <= oh_idle;
      req_seen <= 1'b0;
      finish_o <= 1'b0;
      stall_o  <= 1'b0;
    end else begin
      state    <= state_next;
      finish_o <= (state != oh_idle) && (state_next == oh_idle);
      if (state != oh_setup) begin
        req_seen <= 1'b0;
      end else if (request_valid_i) begin
        req_seen <= 1'b1;
      end
      // Stall stays up until the host starts a new SETUP
      if (start_i) begin
        stall_o <= 1'b0;
      end else if (state == oh_setup && bad_request) begin
        stall_o <= 1'b1;
      end
    end
  end

  // Device state changes only on a completed status handshake
  assign commit_o = (state == oh_status) && handshake && select_i;

  always_comb begin
    case (state)
      oh_setup:  stage_o = st_setup;
      oh_data:   stage_o = st_data;
      oh_status: stage_o = st_status;
      default:   stage_o = st_idle;
    endcase
  end

endmodule

/* hw/device_state_regs.sv */
`timescale 1ns/1ps

module device_state_regs (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 commit_i,
  input  ctrl_pkg::request_t   request_i,
  output ctrl_pkg::dev_state_t dev_state_o,
  output logic                 set_conf_o,
  output logic                 clr_conf_o
);
  import ctrl_pkg::*;

  dev_state_t state;
  logic [6:0] new_address;
  logic [2:0] new_conf;

  assign new_address = request_i.value[6:0];
  assign new_conf    = request_i.value[2:0];

  always_ff @(posedge clock) begin
    if (reset) begin
      state      <= '0;
      set_conf_o <= 1'b0;
      clr_conf_o <= 1'b0;
    end else begin
      set_conf_o <= 1'b0;
      clr_conf_o <= 1'b0;
      if (commit_i) begin
        case (request_i.kind)
          k_set_addr: begin
            state.address    <= new_address;
            // Address zero puts the device back into the default state
            state.enumerated <= |new_address;
          end
          k_set_conf: begin
            state.conf_num   <= new_conf;
            state.configured <= |new_conf;
            set_conf_o       <= |new_conf;
            clr_conf_o       <= ~|new_conf;
          end
          default: begin
            state <= state;
          end
        endcase
      end
    end
  end

  assign dev_state_o = state;

endmodule

/* hw/reply_streamer.sv */
`timescale 1ns/1ps

module reply_streamer (
  input  logic                 clock,
  input  logic                 reset,
  input  ctrl_pkg::stage_e     stage_i,
  input  ctrl_pkg::request_t   request_i,
  input  ctrl_pkg::dev_state_t dev_state_i,
  input  logic                 m_tready_i,
  output logic                 m_tvalid_o,
  output logic                 m_tkeep_o,
  output logic                 m_tlast_o,
  output logic [3:0]           m_tuser_o,
  output logic [7:0]           m_tdata_o
);
  import ctrl_pkg::*;
  import usb_defs_pkg::*;

  localparam int off_w = $clog2(max_packet);

  logic [off_w-1:0] offset;
  logic [6:0]       src_len;
  logic [6:0]       cut_len;
  logic [7:0]       cur_byte;
  logic             active;
  logic             sent;
  logic             zlp;
  logic             last;

  // Reply source and the byte at the current offset
  always_comb begin
    src_len  = '0;
    cur_byte = '0;
    case (request_i.kind)
      k_get_desc: begin
        case (request_i.desc_type)
          desc_device: begin
            src_len = 7'(device_len);
            if (offset < device_len) cur_byte = device_desc[offset];
          end
          desc_configuration: begin
            src_len = 7'(config_len);
            if (offset < config_len) cur_byte = config_desc[offset];
          end
          desc_string: begin
            case (request_i.desc_index)
              8'd0: begin
                src_len = 7'(string0_len);
                if (offset < string0_len) cur_byte = string0_desc[offset];
              end
              8'd1: begin
                src_len = 7'(string1_len);
                if (offset < string1_len) cur_byte = string1_desc[offset];
              end
              8'd2: begin
                src_len = 7'(string2_len);
                if (offset < string2_len) cur_byte = string2_desc[offset];
              end
              8'd3: begin
                src_len = 7'(string3_len);
                if (offset < string3_len) cur_byte = string3_desc[offset];
              end
              default: src_len = '0;
            endcase
          end
          default: src_len = '0;
        endcase
      end
      k_get_conf: begin
        src_len  = 7'd1;
        cur_byte = {5'd0, dev_state_i.conf_num};
      end
      k_get_status: begin
        src_len = 7'd2;
      end
      default: src_len = '0;
    endcase
  end

  // Reply length is the lesser of wLength and the source length
  assign cut_len = (request_i.length < 16'(src_len)) ? request_i.length[6:0] : src_len;

  assign active = (stage_i == st_data && request_i.dir_in && src_len != '0) ||
                  (stage_i == st_status && !request_i.dir_in);

  assign last = zlp || ({1'b0, offset} == cut_len - 7'd1);

  // One packet per stage, valid held until the last beat is taken
  always_ff @(posedge clock) begin
    if (reset) begin
      m_tvalid_o <= 1'b0;
      sent       <= 1'b0;
    end else if (active) begin
      if (!m_tvalid_o && !sent) begin
        m_tvalid_o <= 1'b1;
        sent       <= 1'b1;
      end else if (m_tvalid_o && m_tready_i && last) begin
        m_tvalid_o <= 1'b0;
      end
    end else begin
      m_tvalid_o <= 1'b0;
      sent       <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (!m_tvalid_o) begin
      offset <= '0;
      zlp    <= (stage_i == st_status) || (cut_len == '0);
    end else if (m_tready_i && !last) begin
      offset <= offset + 1'b1;
    end
  end

  assign m_tkeep_o = !zlp;
  assign m_tlast_o = last;
  assign m_tuser_o = pid_data1;
  assign m_tdata_o = zlp ? 8'h00 : cur_byte;

endmodule

/* hw/std_request_unit.sv */
`timescale 1ns/1ps

module std_request_unit (
  input  logic       clock,
  input  logic       reset,
  input  logic       select_i,
  input  logic       start_i,
  input  logic       hsk_sent_i,
  input  logic       hsk_recv_i,
  input  logic       timeout_i,
  // SETUP bytes from the packet decoder
  input  logic       s_tvalid_i,
  output logic       s_tready_o,
  input  logic       s_tlast_i,
  input  logic [7:0] s_tdata_i,
  // Reply bytes to the packet encoder
  output logic       m_tvalid_o,
  input  logic       m_tready_i,
  output logic       m_tkeep_o,
  output logic       m_tlast_o,
  output logic [3:0] m_tuser_o,
  output logic [7:0] m_tdata_o,
  output logic       finish_o,
  output logic       stall_o,
  output logic       enumerated_o,
  output logic       configured_o,
  output logic [2:0] conf_num_o,
  output logic [6:0] address_o,
  output logic       set_conf_o,
  output logic       clr_conf_o
);
  import ctrl_pkg::*;

  request_t   request;
  logic       request_valid;
  logic       malformed;
  stage_e     stage;
  logic       commit;
  dev_state_t dev_state;

  setup_collector u_collector (
    .clock           (clock),
    .reset           (reset),
    .stage_i         (stage),
    .s_tvalid_i      (s_tvalid_i),
    .s_tlast_i       (s_tlast_i),
    .s_tdata_i       (s_tdata_i),
    .s_tready_o      (s_tready_o),
    .request_o       (request),
    .request_valid_o (request_valid),
    .malformed_o     (malformed)
  );

  control_stage_fsm u_fsm (
    .clock           (clock),
    .reset           (reset),
    .select_i        (select_i),
    .start_i         (start_i),
    .hsk_sent_i      (hsk_sent_i),
    .hsk_recv_i      (hsk_recv_i),
    .timeout_i       (timeout_i),
    .request_i       (request),
    .request_valid_i (request_valid),
    .malformed_i     (malformed),
    .stage_o         (stage),
    .commit_o        (commit),
    .finish_o        (finish_o),
    .stall_o         (stall_o)
  );

  device_state_regs u_state (
    .clock       (clock),
    .reset       (reset),
    .commit_i    (commit),
    .request_i   (request),
    .dev_state_o (dev_state),
    .set_conf_o  (set_conf_o),
    .clr_conf_o  (clr_conf_o)
  );

  reply_streamer u_streamer (
    .clock       (clock),
    .reset       (reset),
    .stage_i     (stage),
    .request_i   (request),
    .dev_state_i (dev_state),
    .m_tready_i  (m_tready_i),
    .m_tvalid_o  (m_tvalid_o),
    .m_tkeep_o   (m_tkeep_o),
    .m_tlast_o   (m_tlast_o),
    .m_tuser_o   (m_tuser_o),
    .m_tdata_o   (m_tdata_o)
  );

  assign enumerated_o = dev_state.enumerated;
  assign configured_o = dev_state.configured;
  assign conf_num_o   = dev_state.conf_num;
  assign address_o    = dev_state.address;

endmodule

/* testbench/std_request_unit_tb.sv */
`timescale 1ns/1ps

module std_request_unit_tb;

  typedef struct packed {
    logic [6:0] address;
    logic       enumerated;
    logic       configured;
    logic [2:0] conf_num;
  } model_t;

  typedef struct packed {
    logic [7:0][7:0] setup;
    logic [2:0]      last_at;
    logic            exp_stall;
    logic [6:0]      exp_len;
    logic [1:0]      abort;
    model_t          after;
    logic            exp_set;
    logic            exp_clr;
  } entry_t;

  // Ways a data stage can be cut short
  localparam logic [1:0] no_abort    = 2'd0;
  localparam logic [1:0] bus_timeout = 2'd1;
  localparam logic [1:0] deselect    = 2'd2;

  localparam logic [3:0] data1_pid       = 4'b1011;
  localparam int         cycles_per_test = 200;

  // Reference descriptor bytes in wire order
  localparam logic [0:17][7:0] ref_device = {
    8'h12, 8'h01, 8'h00, 8'h02, 8'h00, 8'h00, 8'h00, 8'h40, 8'hCE,
    8'hF4, 8'h03, 8'h00, 8'h00, 8'h01, 8'h01, 8'h02, 8'h03, 8'h01
  };
  localparam logic [0:17][7:0] ref_config = {
    8'h09, 8'h02, 8'h12, 8'h00, 8'h01, 8'h01, 8'h00, 8'h80, 8'h32,
    8'h09, 8'h04, 8'h00, 8'h00, 8'h00, 8'hFF, 8'h00, 8'h00, 8'h00
  };
  localparam logic [0:3][7:0] ref_string0 = {8'h04, 8'h03, 8'h09, 8'h04};
  localparam logic [0:15][7:0] ref_string1 = {
    8'h10, 8'h03, 8'h4F, 8'h00, 8'h50, 8'h00, 8'h45, 8'h00,
    8'h4E, 8'h00, 8'h20, 8'h00, 8'h48, 8'h00, 8'h57, 8'h00
  };
  localparam logic [0:19][7:0] ref_string2 = {
    8'h14, 8'h03, 8'h43, 8'h00, 8'h54, 8'h00, 8'h52, 8'h00, 8'h4C, 8'h00,
    8'h20, 8'h00, 8'h55, 8'h00, 8'h4E, 8'h00, 8'h49, 8'h00, 8'h54, 8'h00
  };
  localparam logic [0:13][7:0] ref_string3 = {
    8'h0E, 8'h03, 8'h53, 8'h00, 8'h4E, 8'h00, 8'h30, 8'h00,
    8'h30, 8'h00, 8'h30, 8'h00, 8'h31, 8'h00
  };

  logic       clock = 1'b0;
  logic       reset;
  logic       select_i;
  logic       start_i;
  logic       hsk_sent_i;
  logic       hsk_recv_i;
  logic       timeout_i;
  logic       s_tvalid_i;
  logic       s_tready_o;
  logic       s_tlast_i;
  logic [7:0] s_tdata_i;
  logic       m_tvalid_o;
  logic       m_tready_i;
  logic       m_tkeep_o;
  logic       m_tlast_o;
  logic [3:0] m_tuser_o;
  logic [7:0] m_tdata_o;
  logic       finish_o;
  logic       stall_o;
  logic       enumerated_o;
  logic       configured_o;
  logic [2:0] conf_num_o;
  logic [6:0] address_o;
  logic       set_conf_o;
  logic       clr_conf_o;

  entry_t      tests[$];
  string       test_names[$];
  string       cur_name;
  model_t      model;
  model_t      s_zero;
  model_t      s_addr;
  model_t      s_conf;
  int          set_pulses = 0;
  int          clr_pulses = 0;
  int          cycles = 0;
  int          limit = 0;
  logic [31:0] lcg_state = 32'd30876;

  std_request_unit DUT (.*);

  always #2 clock = ~clock;

  always @(negedge clock) begin
    if (set_conf_o) set_pulses <= set_pulses + 1;
    if (clr_conf_o) clr_pulses <= clr_pulses + 1;
  end

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles > limit) begin
      $display("Timeout: the run did not finish within %0d cycles", limit);
      $display("RESULT: FAIL");
      $fatal(1);
    end
  end

  // Ready high on about three beats out of four
  function automatic logic next_ready();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[17:16] != 2'b00;
  endfunction

  function automatic logic [7:0][7:0] make_setup(input logic [7:0] req_type,
                                                 input logic [7:0] request,
                                                 input logic [15:0] value, input logic [15:0] index,
                                                 input logic [15:0] length);
    return {length, index, value, request, req_type};
  endfunction

  function automatic model_t dev_model(input logic [6:0] address, input logic enumerated,
                                       input logic configured, input logic [2:0] conf_num);
    return {address, enumerated, configured, conf_num};
  endfunction

  function automatic logic [7:0] reference_byte(input logic [7:0][7:0] setup, input int idx,
                                                input logic [2:0] conf_num);
    logic [7:0] value;
    value = 8'h00;
    if (setup[1] == 8'h06) begin
      case ({setup[3], setup[2]})
        16'h0100: value = ref_device[idx];
        16'h0200: value = ref_config[idx];
        16'h0300: value = ref_string0[idx];
        16'h0301: value = ref_string1[idx];
        16'h0302: value = ref_string2[idx];
        16'h0303: value = ref_string3[idx];
        default:  value = 8'h00;
      endcase
    end else if (setup[1] == 8'h08) begin
      value = {5'd0, conf_num};
    end
    return value;
  endfunction

  task automatic check_equal(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected)
    else begin
      $display("FAIL %s: %s expected %0h, actual %0h", cur_name, what, expected, actual);
      $display("RESULT: FAIL");
      $fatal(1);
    end
  endtask

  task automatic check_state(input model_t m);
    check_equal("address_o", m.address, address_o);
    check_equal("enumerated_o", m.enumerated, enumerated_o);
    check_equal("configured_o", m.configured, configured_o);
    check_equal("conf_num_o", m.conf_num, conf_num_o);
  endtask

  task automatic add_test(input string name, input logic [7:0][7:0] setup,
                          input logic [2:0] last_at, input logic stall, input int len,
                          input logic [1:0] abort, input model_t after, input logic [1:0] pulses);
    entry_t e;
    e.setup     = setup;
    e.last_at   = last_at;
    e.exp_stall = stall;
    e.exp_len   = 7'(len);
    e.abort     = abort;
    e.after     = after;
    e.exp_set   = pulses[1];
    e.exp_clr   = pulses[0];
    tests.push_back(e);
    test_names.push_back(name);
  endtask

  task automatic pulse_ack_sent();
    hsk_sent_i = 1'b1;
    @(negedge clock);
    hsk_sent_i = 1'b0;
  endtask

  task automatic pulse_ack_recv();
    hsk_recv_i = 1'b1;
    @(negedge clock);
    hsk_recv_i = 1'b0;
  endtask

  task automatic wait_finish();
    while (finish_o !== 1'b1) @(negedge clock);
  endtask

  // SETUP bytes up to and including the one marked with tlast
  task automatic send_setup(input entry_t t);
    int n;
    n = 0;
    while (n <= t.last_at) begin
      s_tvalid_i = 1'b1;
      s_tdata_i  = t.setup[n];
      s_tlast_i  = (n == t.last_at);
      if (s_tready_o) n++;
      @(negedge clock);
    end
    s_tvalid_i = 1'b0;
    s_tlast_i  = 1'b0;
  endtask

  task automatic collect_reply(input entry_t t, input logic zero_length, input int stop_at);
    int         beats;
    logic       ready;
    logic       held;
    logic [7:0] held_data;
    logic       done;
    beats = 0;
    held  = 1'b0;
    done  = 1'b0;
    held_data = 8'h00;
    while (!done) begin
      if (stop_at != 0 && beats == stop_at) begin
        m_tready_i = 1'b0;
        done = 1'b1;
      end else begin
        ready = next_ready();
        m_tready_i = ready;
        if (held) begin
          check_equal("held m_tvalid_o", 1'b1, m_tvalid_o);
          check_equal("held m_tdata_o", held_data, m_tdata_o);
        end
        held = m_tvalid_o && !ready;
        held_data = m_tdata_o;
        if (m_tvalid_o && ready) begin
          check_equal("m_tuser_o", data1_pid, m_tuser_o);
          if (zero_length) begin
            check_equal("zero-length m_tkeep_o", 1'b0, m_tkeep_o);
            check_equal("zero-length m_tlast_o", 1'b1, m_tlast_o);
          end else begin
            check_equal("m_tkeep_o", 1'b1, m_tkeep_o);
            check_equal("m_tdata_o", reference_byte(t.setup, beats, model.conf_num), m_tdata_o);
            check_equal("m_tlast_o", beats == t.exp_len - 1, m_tlast_o);
          end
          beats++;
          done = m_tlast_o;
        end
        @(negedge clock);
      end
    end
    if (stop_at == 0) begin
      check_equal("beat count", zero_length ? 1 : t.exp_len, beats);
      check_equal("m_tvalid_o after last", 1'b0, m_tvalid_o);
    end
    m_tready_i = 1'b0;
  endtask

  task automatic run_transfer(input entry_t t);
    int set_before;
    int clr_before;
    set_before = set_pulses;
    clr_before = clr_pulses;
    start_i = 1'b1;
    @(negedge clock);
    start_i = 1'b0;
    send_setup(t);
    check_equal("s_tready_o after last byte", 1'b0, s_tready_o);
    @(negedge clock);
    check_equal("stall_o", t.exp_stall, stall_o);
    if (t.exp_stall) begin
      // The SETUP packet is acknowledged even when the request stalls
      pulse_ack_sent();
      repeat (8) begin
        check_equal("m_tvalid_o on stall", 1'b0, m_tvalid_o);
        @(negedge clock);
      end
    end else begin
      pulse_ack_sent();
      if (t.setup[0][7]) begin
        collect_reply(t, 1'b0, (t.abort == no_abort) ? 0 : 3);
        case (t.abort)
          bus_timeout: begin
            timeout_i = 1'b1;
            @(negedge clock);
            timeout_i = 1'b0;
          end
          deselect: select_i = 1'b0;
          default: begin
            pulse_ack_recv();
            pulse_ack_sent();
          end
        endcase
      end else begin
        collect_reply(t, 1'b1, 0);
        // Nothing changes before the status handshake
        check_state(model);
        pulse_ack_recv();
      end
      wait_finish();
      select_i = 1'b1;
    end
    @(negedge clock);
    check_equal("m_tvalid_o when idle", 1'b0, m_tvalid_o);
    check_state(t.after);
    check_equal("set_conf_o pulses", t.exp_set, set_pulses - set_before);
    check_equal("clr_conf_o pulses", t.exp_clr, clr_pulses - clr_before);
    model = t.after;
  endtask

  initial begin
    reset      = 1'b1;
    select_i   = 1'b1;
    start_i    = 1'b0;
    hsk_sent_i = 1'b0;
    hsk_recv_i = 1'b0;
    timeout_i  = 1'b0;
    s_tvalid_i = 1'b0;
    s_tlast_i  = 1'b0;
    s_tdata_i  = 8'h00;
    m_tready_i = 1'b0;
    s_zero = dev_model(7'd0, 1'b0, 1'b0, 3'd0);
    s_addr = dev_model(7'd5, 1'b1, 1'b0, 3'd0);
    s_conf = dev_model(7'd5, 1'b1, 1'b1, 3'd1);

    add_test("get_device_desc", make_setup(8'h80, 8'h06, 16'h0100, 16'h0000, 16'h0040),
             7, 0, 18, no_abort, s_zero, 2'b00);
    add_test("get_config_desc_9", make_setup(8'h80, 8'h06, 16'h0200, 16'h0000, 16'h0009),
             7, 0, 9, no_abort, s_zero, 2'b00);
    add_test("get_string0", make_setup(8'h80, 8'h06, 16'h0300, 16'h0000, 16'h00FF),
             7, 0, 4, no_abort, s_zero, 2'b00);
    add_test("get_string1", make_setup(8'h80, 8'h06, 16'h0301, 16'h0409, 16'h0040),
             7, 0, 16, no_abort, s_zero, 2'b00);
    add_test("get_string2_cut", make_setup(8'h80, 8'h06, 16'h0302, 16'h0409, 16'h000A),
             7, 0, 10, no_abort, s_zero, 2'b00);
    add_test("get_string3", make_setup(8'h80, 8'h06, 16'h0303, 16'h0409, 16'h0040),
             7, 0, 14, no_abort, s_zero, 2'b00);
    add_test("set_address_5", make_setup(8'h00, 8'h05, 16'h0005, 16'h0000, 16'h0000),
             7, 0, 0, no_abort, s_addr, 2'b00);
    add_test("get_status", make_setup(8'h80, 8'h00, 16'h0000, 16'h0000, 16'h0002),
             7, 0, 2, no_abort, s_addr, 2'b00);
    add_test("set_configuration_1", make_setup(8'h00, 8'h09, 16'h0001, 16'h0000, 16'h0000),
             7, 0, 0, no_abort, s_conf, 2'b10);
    add_test("get_configuration_1", make_setup(8'h80, 8'h08, 16'h0000, 16'h0000, 16'h0001),
             7, 0, 1, no_abort, s_conf, 2'b00);
    add_test("unsupported_set_feature", make_setup(8'h00, 8'h03, 16'h0001, 16'h0000, 16'h0000),
             7, 1, 0, no_abort, s_conf, 2'b00);
    add_test("early_tlast", make_setup(8'h80, 8'h06, 16'h0100, 16'h0000, 16'h0040),
             3, 1, 0, no_abort, s_conf, 2'b00);
    add_test("get_device_desc_8", make_setup(8'h80, 8'h06, 16'h0100, 16'h0000, 16'h0008),
             7, 0, 8, no_abort, s_conf, 2'b00);
    add_test("timeout_in_data", make_setup(8'h80, 8'h06, 16'h0200, 16'h0000, 16'h0040),
             7, 0, 18, bus_timeout, s_conf, 2'b00);
    add_test("deselect_in_data", make_setup(8'h80, 8'h06, 16'h0100, 16'h0000, 16'h0040),
             7, 0, 18, deselect, s_conf, 2'b00);
    add_test("unknown_string4", make_setup(8'h80, 8'h06, 16'h0304, 16'h0409, 16'h0040),
             7, 1, 0, no_abort, s_conf, 2'b00);
    add_test("set_configuration_0", make_setup(8'h00, 8'h09, 16'h0000, 16'h0000, 16'h0000),
             7, 0, 0, no_abort, s_addr, 2'b01);
    add_test("get_configuration_0", make_setup(8'h80, 8'h08, 16'h0000, 16'h0000, 16'h0001),
             7, 0, 1, no_abort, s_addr, 2'b00);
    limit = tests.size() * cycles_per_test;

    repeat (16) @(negedge clock);
    reset = 1'b0;
    @(negedge clock);
    cur_name = "after_reset";
    check_equal("s_tready_o", 1'b0, s_tready_o);
    check_equal("m_tvalid_o", 1'b0, m_tvalid_o);
    check_equal("finish_o", 1'b0, finish_o);
    check_equal("stall_o", 1'b0, stall_o);
    check_equal("set_conf_o", 1'b0, set_conf_o);
    check_equal("clr_conf_o", 1'b0, clr_conf_o);
    check_state(s_zero);
    model = s_zero;

    for (int i = 0; i < tests.size(); i++) begin
      cur_name = test_names[i];
      run_transfer(tests[i]);
    end
    $display("RESULT: PASS");
    $finish;
  end

endmodule

/* std_request_unit.f */
hw/usb_defs_pkg.sv
hw/ctrl_pkg.sv
hw/setup_collector.sv
hw/control_stage_fsm.sv
hw/device_state_regs.sv
hw/reply_streamer.sv
hw/std_request_unit.sv
testbench/std_request_unit_tb.sv

/* Bender.yml */
package:
  name: std_request_unit

sources:
  - hw/usb_defs_pkg.sv
  - hw/ctrl_pkg.sv
  - hw/setup_collector.sv
  - hw/control_stage_fsm.sv
  - hw/device_state_regs.sv
  - hw/reply_streamer.sv
  - hw/std_request_unit.sv
  - target: test
    files:
      - testbench/std_request_unit_tb.sv
